// File: verilog/mipsPkg.sv
`default_nettype none

package mipsPkg;

	////////////////////
	// Opcodes and function codes
	localparam logic [5:0] opR    = 6'b000000;
	localparam logic [5:0] opBeq  = 6'b000100;
	localparam logic [5:0] opJ    = 6'b000010;
	localparam logic [5:0] opJal  = 6'b000011;
	localparam logic [5:0] opLui  = 6'b001111;
	localparam logic [5:0] opLw   = 6'b100011;
	localparam logic [5:0] opOri  = 6'b001101;
	localparam logic [5:0] opSw   = 6'b101011;

	localparam logic [5:0] fnAddu = 6'b100001;
	localparam logic [5:0] fnSubu = 6'b100011;
	localparam logic [5:0] fnJr   = 6'b001000;
	localparam logic [5:0] fnNop  = 6'b000000;

	////////////////////
	// Select encodings, zero is always the quiet choice
	localparam logic [1:0] npcSeq    = 2'd0;
	localparam logic [1:0] npcBranch = 2'd1;
	localparam logic [1:0] npcJump   = 2'd2;
	localparam logic [1:0] npcReg    = 2'd3;

	localparam logic [1:0] extZero   = 2'd0;
	localparam logic [1:0] extSign   = 2'd1;
	localparam logic [1:0] extHigh   = 2'd2;

	localparam logic [2:0] aluAdd    = 3'd0;
	localparam logic [2:0] aluSub    = 3'd1;
	localparam logic [2:0] aluOr     = 3'd2;

	localparam logic [1:0] dstRd     = 2'd0;
	localparam logic [1:0] dstRt     = 2'd1;
	localparam logic [1:0] dst31     = 2'd2;

	localparam logic [1:0] dataAlu   = 2'd0;
	localparam logic [1:0] dataMem   = 2'd1;
	localparam logic [1:0] dataLink  = 2'd2;

	localparam logic [1:0] bReg      = 2'd0;
	localparam logic [1:0] bImm      = 2'd1;

	// Stages left until the result exists, seen from execute
	localparam logic [1:0] tnewAlu   = 2'd1;
	localparam logic [1:0] tnewMem   = 2'd2;
	localparam logic [1:0] tnewLink  = 2'd1;

	localparam logic [1:0] fwdNone   = 2'd0;
	localparam logic [1:0] fwdMem    = 2'd1;
	localparam logic [1:0] fwdWb     = 2'd2;

	////////////////////
	// One fetched word, three views
	typedef union packed {
		struct packed {
			logic [5:0] op;
			logic [4:0] rs;
			logic [4:0] rt;
			logic [4:0] rd;
			logic [4:0] shamt;
			logic [5:0] funct;
		} rType;
		struct packed {
			logic [5:0]  op;
			logic [4:0]  rs;
			logic [4:0]  rt;
			logic [15:0] imm16;
		} iType;
		struct packed {
			logic [5:0]  op;
			logic [25:0] target26;
		} jType;
	} instrWord;

	typedef struct packed {
		logic [1:0] npcOp;
		logic [1:0] extOp;
		logic [2:0] aluOp;
		logic [1:0] dstSel;
		logic [1:0] dataSel;
		logic [1:0] bSel;
		logic       regWrite;
		logic       memWrite;
		logic       useRsEarly;
		logic       useRsLate;
		logic       useRtEarly;
		logic       useRtLate;
		logic [1:0] tnew;
	} ctrlSignals;

	typedef struct packed {
		logic        valid;
		logic [4:0]  addr;
		logic [31:0] data;
	} regWriteEvent;

	typedef struct packed {
		logic        valid;
		logic [31:0] addr;
		logic [31:0] data;
	} storeEvent;

endpackage

`default_nettype wire

// File: verilog/controlDecoder.sv
`timescale 1ns/100ps
`default_nettype none

module controlDecoder (
	input  mipsPkg::instrWord   instr,
	output mipsPkg::ctrlSignals ctrl
);

	logic isR;
	logic addu;
	logic subu;
	logic jr;
	logic nop;
	logic beq;
	logic j;
	logic jal;
	logic lui;
	logic lw;
	logic ori;
	logic sw;
	logic known;
	logic aluWriter;

	// R-type words split on the function field
	assign isR  = (instr.rType.op == mipsPkg::opR);
	assign addu = isR && (instr.rType.funct == mipsPkg::fnAddu);
	assign subu = isR && (instr.rType.funct == mipsPkg::fnSubu);
	assign jr   = isR && (instr.rType.funct == mipsPkg::fnJr);
	assign nop  = isR && (instr.rType.funct == mipsPkg::fnNop);

	assign beq  = (instr.iType.op == mipsPkg::opBeq);
	assign j    = (instr.jType.op == mipsPkg::opJ);
	assign jal  = (instr.jType.op == mipsPkg::opJal);
	assign lui  = (instr.iType.op == mipsPkg::opLui);
	assign lw   = (instr.iType.op == mipsPkg::opLw);
	assign ori  = (instr.iType.op == mipsPkg::opOri);
	assign sw   = (instr.iType.op == mipsPkg::opSw);

	assign known = addu | subu | jr | nop | beq | j | jal | lui | lw | ori | sw;
	assign aluWriter = addu | subu | ori | lui;

	always_comb begin
		ctrl = '0;
		// Anything outside the subset stays a bubble
		if (known) begin
			ctrl.npcOp = beq ? mipsPkg::npcBranch :
				(j || jal) ? mipsPkg::npcJump :
				jr ? mipsPkg::npcReg : mipsPkg::npcSeq;

			ctrl.extOp = (lw || sw) ? mipsPkg::extSign :
				lui ? mipsPkg::extHigh : mipsPkg::extZero;

			// lui adds the shifted immediate to $0
			ctrl.aluOp = subu ? mipsPkg::aluSub :
				ori ? mipsPkg::aluOr : mipsPkg::aluAdd;

			ctrl.dstSel = (ori || lw || lui) ? mipsPkg::dstRt :
				jal ? mipsPkg::dst31 : mipsPkg::dstRd;

			ctrl.dataSel = lw ? mipsPkg::dataMem :
				jal ? mipsPkg::dataLink : mipsPkg::dataAlu;

			ctrl.bSel = (ori || lw || sw || lui) ? mipsPkg::bImm : mipsPkg::bReg;

			ctrl.regWrite = aluWriter | lw | jal;
			ctrl.memWrite = sw;

			// Early means decode, late means execute
			ctrl.useRsEarly = beq | jr;
			ctrl.useRsLate  = addu | subu | ori | lw | sw;
			ctrl.useRtEarly = beq;
			ctrl.useRtLate  = addu | subu | sw;

			ctrl.tnew = lw ? mipsPkg::tnewMem :
				jal ? mipsPkg::tnewLink :
				aluWriter ? mipsPkg::tnewAlu : 2'd0;
		end
	end

endmodule

`default_nettype wire

// File: verilog/registerFile.sv
`timescale 1ns/100ps
`default_nettype none

module registerFile (
	input  logic                  clk,
	input  logic                  reset,
	input  logic [4:0]            readAddrA,
	input  logic [4:0]            readAddrB,
	output logic [31:0]           readDataA,
	output logic [31:0]           readDataB,
	input  mipsPkg::regWriteEvent writeEvent
);

	logic [31:0] regs [32];
	logic        writing;

	assign writing = writeEvent.valid && (writeEvent.addr != 5'd0);

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (writing) begin
			regs[writeEvent.addr] <= writeEvent.data;
		end
	end

	// Same-cycle write wins over the stored value
	function automatic logic [31:0] readPort(input logic [4:0] addr);
		if (addr == 5'd0) begin
			return '0;
		end
		if (writing && (addr == writeEvent.addr)) begin
			return writeEvent.data;
		end
		return regs[addr];
	endfunction

	always_comb begin
		readDataA = readPort(readAddrA);
		readDataB = readPort(readAddrB);
	end

endmodule

`default_nettype wire

// File: verilog/nextPcUnit.sv
`timescale 1ns/100ps
`default_nettype none

module nextPcUnit (
	input  logic              clk,
	input  logic              reset,
	input  logic              stall,
	input  mipsPkg::instrWord decodeInstr,
	input  logic [31:0]       decodePc,
	input  logic [1:0]        npcOp,
	input  logic [1:0]        extOp,
	input  logic [31:0]       rsValue,
	input  logic [31:0]       rtValue,
	output logic [31:0]       pc,
	output logic [31:0]       extImm
);

	logic [15:0] imm;
	logic [31:0] seqPc;
	logic [31:0] branchTarget;
	logic [31:0] jumpTarget;
	logic [31:0] nextPc;

	assign imm          = decodeInstr.iType.imm16;
	assign seqPc        = pc + 32'd4;
	assign branchTarget = decodePc + 32'd4 + {{14{imm[15]}}, imm, 2'b00};
	assign jumpTarget   = {decodePc[31:28], decodeInstr.jType.target26, 2'b00};

	always_comb begin
		case (extOp)
			mipsPkg::extSign: extImm = {{16{imm[15]}}, imm};
			mipsPkg::extHigh: extImm = {imm, 16'h0000};
			mipsPkg::extZero: extImm = {16'h0000, imm};
			default:          extImm = {16'h0000, imm};
		endcase
	end

	// Fetch PC already points at the delay slot
	always_comb begin
		case (npcOp)
			mipsPkg::npcBranch: nextPc = (rsValue == rtValue) ? branchTarget : seqPc;
			mipsPkg::npcJump:   nextPc = jumpTarget;
			mipsPkg::npcReg:    nextPc = rsValue;
			default:            nextPc = seqPc;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= '0;
		end else if (!stall) begin
			pc <= nextPc;
		end
	end

endmodule

`default_nettype wire

// File: verilog/hazardUnit.sv
`timescale 1ns/100ps
`default_nettype none

module hazardUnit (
	input  mipsPkg::instrWord   decodeInstr,
	input  mipsPkg::ctrlSignals decodeCtrl,
	input  mipsPkg::ctrlSignals execCtrl,
	input  mipsPkg::ctrlSignals memCtrl,
	input  logic [4:0]          execDst,
	input  logic [4:0]          memDst,
	input  logic [4:0]          wbDst,
	input  logic [1:0]          memTnewLeft,
	output logic                stall,
	output logic [1:0]          fwdDecodeRs,
	output logic [1:0]          fwdDecodeRt,
	output logic [1:0]          fwdExecRs,
	output logic [1:0]          fwdExecRt
);

	logic [4:0] rs;
	logic [4:0] rt;
	logic       execRsHit;
	logic       execRtHit;
	logic       memRsHit;
	logic       memRtHit;
	logic       wbRsHit;
	logic       wbRtHit;

	function automatic logic hits(input logic [4:0] src, input logic writes,
		input logic [4:0] dst);
		return writes && (src != 5'd0) && (src == dst);
	endfunction

	// Tuse is 0 for early and 1 for late uses
	function automatic logic tooSoon(input logic early, input logic late,
		input logic [1:0] left);
		return (early && (left > 2'd0)) || (late && (left > 2'd1));
	endfunction

	assign rs = decodeInstr.rType.rs;
	assign rt = decodeInstr.rType.rt;

	assign execRsHit = hits(rs, execCtrl.regWrite, execDst);
	assign execRtHit = hits(rt, execCtrl.regWrite, execDst);
	assign memRsHit  = hits(rs, memCtrl.regWrite, memDst);
	assign memRtHit  = hits(rt, memCtrl.regWrite, memDst);
	// wbDst is zero when writeback is idle
	assign wbRsHit   = hits(rs, 1'b1, wbDst);
	assign wbRtHit   = hits(rt, 1'b1, wbDst);

	// Only the nearest producer of a register matters
	always_comb begin
		stall = 1'b0;
		if (execRsHit) begin
			stall |= tooSoon(decodeCtrl.useRsEarly, decodeCtrl.useRsLate, execCtrl.tnew);
		end else if (memRsHit) begin
			stall |= tooSoon(decodeCtrl.useRsEarly, decodeCtrl.useRsLate, memTnewLeft);
		end
		if (execRtHit) begin
			stall |= tooSoon(decodeCtrl.useRtEarly, decodeCtrl.useRtLate, execCtrl.tnew);
		end else if (memRtHit) begin
			stall |= tooSoon(decodeCtrl.useRtEarly, decodeCtrl.useRtLate, memTnewLeft);
		end
	end

	// Decode selects apply now
	assign fwdDecodeRs = memRsHit ? mipsPkg::fwdMem : wbRsHit ? mipsPkg::fwdWb : mipsPkg::fwdNone;
	assign fwdDecodeRt = memRtHit ? mipsPkg::fwdMem : wbRtHit ? mipsPkg::fwdWb : mipsPkg::fwdNone;

	// Execute selects travel with the instruction, producers move one stage on
	assign fwdExecRs = execRsHit ? mipsPkg::fwdMem : memRsHit ? mipsPkg::fwdWb : mipsPkg::fwdNone;
	assign fwdExecRt = execRtHit ? mipsPkg::fwdMem : memRtHit ? mipsPkg::fwdWb : mipsPkg::fwdNone;

endmodule

`default_nettype wire

// File: verilog/executeUnit.sv
`timescale 1ns/100ps
`default_nettype none

module executeUnit (
	input  mipsPkg::ctrlSignals ctrl,
	input  logic [31:0]         rsValue,
	input  logic [31:0]         rtValue,
	input  logic [31:0]         extImm,
	output logic [31:0]         result
);

	logic [31:0] operandB;

	assign operandB = (ctrl.bSel == mipsPkg::bImm) ? extImm : rtValue;

	// No overflow traps, addu and subu wrap
	always_comb begin
		case (ctrl.aluOp)
			mipsPkg::aluSub: result = rsValue - operandB;
			mipsPkg::aluOr:  result = rsValue | operandB;
			mipsPkg::aluAdd: result = rsValue + operandB;
			default:         result = rsValue + operandB;
		endcase
	end

endmodule

`default_nettype wire

// File: verilog/memoryBank.sv
`timescale 1ns/100ps
`default_nettype none

module memoryBank (
	input  logic              clk,
	input  logic              reset,
	input  logic              loadValid,
	input  logic [7:0]        loadAddr,
	input  logic [31:0]       loadWord,
	input  logic [31:0]       fetchPc,
	output mipsPkg::instrWord fetchInstr,
	input  logic [31:0]       dataAddr,
	input  logic [31:0]       dataWrite,
	input  logic              dataWriteEnable,
	output logic [31:0]       dataRead
);

	logic [31:0] instrWords [256];
	logic [31:0] dataWords [256];

	// Program load only while the core sits in reset
	always_ff @(posedge clk) begin
		if (reset && loadValid) begin
			instrWords[loadAddr] <= loadWord;
		end
	end

	assign fetchInstr = instrWords[fetchPc[9:2]];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 256; i++) begin
				dataWords[i] <= '0;
			end
		end else if (dataWriteEnable) begin
			dataWords[dataAddr[9:2]] <= dataWrite;
		end
	end

	// Word addressed, low byte bits ignored
	assign dataRead = dataWords[dataAddr[9:2]];

endmodule

`default_nettype wire

// File: verilog/mipsCore.sv
`timescale 1ns/100ps
`default_nettype none

module mipsCore (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  loadValid,
	input  logic [7:0]            loadAddr,
	input  logic [31:0]           loadWord,
	output mipsPkg::regWriteEvent regWriteOut,
	output mipsPkg::storeEvent    storeOut
);

	////////////////////
	// Pipeline registers
	typedef struct packed {
		mipsPkg::instrWord instr;
		logic [31:0]       pc;
	} fetchDecodeReg;

	typedef struct packed {
		mipsPkg::instrWord   instr;
		logic [31:0]         pc;
		mipsPkg::ctrlSignals ctrl;
		logic [31:0]         rsValue;
		logic [31:0]         rtValue;
		logic [31:0]         extImm;
		logic [1:0]          fwdRs;
		logic [1:0]          fwdRt;
	} decodeExecReg;

	typedef struct packed {
		mipsPkg::instrWord   instr;
		logic [31:0]         pc;
		mipsPkg::ctrlSignals ctrl;
		logic [31:0]         rtValue;
		logic [31:0]         result;
	} execMemReg;

	typedef struct packed {
		mipsPkg::instrWord   instr;
		logic [31:0]         pc;
		mipsPkg::ctrlSignals ctrl;
		logic [31:0]         result;
		logic [31:0]         memData;
	} memWbReg;

	fetchDecodeReg       fdQ;
	decodeExecReg        deQ;
	execMemReg           emQ;
	memWbReg             mwQ;
	mipsPkg::instrWord   fetchInstr;
	mipsPkg::ctrlSignals decodeCtrl;
	logic [31:0]         pc;
	logic [31:0]         extImm;
	logic [31:0]         rfRs;
	logic [31:0]         rfRt;
	logic [31:0]         decodeRs;
	logic [31:0]         decodeRt;
	logic [31:0]         execRs;
	logic [31:0]         execRt;
	logic [31:0]         aluResult;
	logic [31:0]         memValue;
	logic [31:0]         wbValue;
	logic [31:0]         dataRead;
	logic                stall;
	logic [1:0]          fwdDecodeRs;
	logic [1:0]          fwdDecodeRt;
	logic [1:0]          fwdExecRs;
	logic [1:0]          fwdExecRt;
	logic [4:0]          execDst;
	logic [4:0]          memDst;
	logic [4:0]          wbDst;
	logic [1:0]          memTnewLeft;

	function automatic logic [4:0] destOf(input mipsPkg::instrWord instr,
		input logic [1:0] sel);
		case (sel)
			mipsPkg::dstRd: return instr.rType.rd;
			mipsPkg::dstRt: return instr.iType.rt;
			mipsPkg::dst31: return 5'd31;
			default:        return 5'd0;
		endcase
	endfunction

	function automatic logic [31:0] fwdPick(input logic [1:0] sel, input logic [31:0] own,
		input logic [31:0] fromMem, input logic [31:0] fromWb);
		case (sel)
			mipsPkg::fwdMem: return fromMem;
			mipsPkg::fwdWb:  return fromWb;
			default:         return own;
		endcase
	endfunction

	////////////////////
	// Fetch and decode
	memoryBank u_memoryBank (
		.clk             (clk),
		.reset           (reset),
		.loadValid       (loadValid),
		.loadAddr        (loadAddr),
		.loadWord        (loadWord),
		.fetchPc         (pc),
		.fetchInstr      (fetchInstr),
		.dataAddr        (emQ.result),
		.dataWrite       (emQ.rtValue),
		.dataWriteEnable (emQ.ctrl.memWrite),
		.dataRead        (dataRead)
	);

	controlDecoder u_controlDecoder (
		.instr (fdQ.instr),
		.ctrl  (decodeCtrl)
	);

	registerFile u_registerFile (
		.clk        (clk),
		.reset      (reset),
		.readAddrA  (fdQ.instr.rType.rs),
		.readAddrB  (fdQ.instr.rType.rt),
		.readDataA  (rfRs),
		.readDataB  (rfRt),
		.writeEvent (regWriteOut)
	);

	assign decodeRs = fwdPick(fwdDecodeRs, rfRs, memValue, wbValue);
	assign decodeRt = fwdPick(fwdDecodeRt, rfRt, memValue, wbValue);

	nextPcUnit u_nextPcUnit (
		.clk         (clk),
		.reset       (reset),
		.stall       (stall),
		.decodeInstr (fdQ.instr),
		.decodePc    (fdQ.pc),
		.npcOp       (decodeCtrl.npcOp),
		.extOp       (decodeCtrl.extOp),
		.rsValue     (decodeRs),
		.rtValue     (decodeRt),
		.pc          (pc),
		.extImm      (extImm)
	);

	hazardUnit u_hazardUnit (
		.decodeInstr (fdQ.instr),
		.decodeCtrl  (decodeCtrl),
		.execCtrl    (deQ.ctrl),
		.memCtrl     (emQ.ctrl),
		.execDst     (execDst),
		.memDst      (memDst),
		.wbDst       (wbDst),
		.memTnewLeft (memTnewLeft),
		.stall       (stall),
		.fwdDecodeRs (fwdDecodeRs),
		.fwdDecodeRt (fwdDecodeRt),
		.fwdExecRs   (fwdExecRs),
		.fwdExecRt   (fwdExecRt)
	);

	////////////////////
	// Execute, memory, writeback
	assign execRs = fwdPick(deQ.fwdRs, deQ.rsValue, memValue, wbValue);
	assign execRt = fwdPick(deQ.fwdRt, deQ.rtValue, memValue, wbValue);

	executeUnit u_executeUnit (
		.ctrl    (deQ.ctrl),
		.rsValue (execRs),
		.rtValue (execRt),
		.extImm  (deQ.extImm),
		.result  (aluResult)
	);

	assign execDst     = destOf(deQ.instr, deQ.ctrl.dstSel);
	assign memDst      = destOf(emQ.instr, emQ.ctrl.dstSel);
	assign memTnewLeft = (emQ.ctrl.tnew == 2'd0) ? 2'd0 : emQ.ctrl.tnew - 2'd1;

	// Link address is jal plus 8, past the delay slot
	assign memValue = (emQ.ctrl.dataSel == mipsPkg::dataLink) ? emQ.pc + 32'd8 : emQ.result;

	always_comb begin
		case (mwQ.ctrl.dataSel)
			mipsPkg::dataMem:  wbValue = mwQ.memData;
			mipsPkg::dataLink: wbValue = mwQ.pc + 32'd8;
			default:           wbValue = mwQ.result;
		endcase
	end

	assign wbDst = mwQ.ctrl.regWrite ? destOf(mwQ.instr, mwQ.ctrl.dstSel) : 5'd0;

	assign regWriteOut = '{valid: (wbDst != 5'd0), addr: wbDst, data: wbValue};
	assign storeOut    = '{valid: emQ.ctrl.memWrite, addr: emQ.result, data: emQ.rtValue};

	always_ff @(posedge clk) begin
		if (reset) begin
			fdQ <= '0;
			deQ <= '0;
			emQ <= '0;
			mwQ <= '0;
		end else begin
			// Stall holds fetch/decode and sends a bubble on
			if (!stall) begin
				fdQ <= '{instr: fetchInstr, pc: pc};
			end
			if (stall) begin
				deQ <= '0;
			end else begin
				deQ <= '{instr: fdQ.instr, pc: fdQ.pc, ctrl: decodeCtrl,
					rsValue: decodeRs, rtValue: decodeRt, extImm: extImm,
					fwdRs: fwdExecRs, fwdRt: fwdExecRt};
			end
			emQ <= '{instr: deQ.instr, pc: deQ.pc, ctrl: deQ.ctrl,
				rtValue: execRt, result: aluResult};
			mwQ <= '{instr: emQ.instr, pc: emQ.pc, ctrl: emQ.ctrl,
				result: emQ.result, memData: dataRead};
		end
	end

endmodule

`default_nettype wire

// File: tb/pipeline_checker.sv
`timescale 1ns/100ps
`default_nettype none

module pipelineChecker (
	input logic                  clk,
	input logic                  reset,
	input logic                  stall,
	input mipsPkg::regWriteEvent regWriteOut,
	input mipsPkg::storeEvent    storeOut
);

	// Outputs stay quiet while the core is held in reset
	quietInReset: assert property (@(posedge clk)
		reset |-> (!regWriteOut.valid && !storeOut.valid))
		else $error("event valid while reset is high");

	// Load followed by beq or jr is the longest stall
	stallBound: assert property (@(posedge clk) disable iff (reset)
		!(stall && $past(stall) && $past(stall, 2)))
		else $error("stall held for more than two cycles");

	noWriteToZero: assert property (@(posedge clk) disable iff (reset)
		regWriteOut.valid |-> (regWriteOut.addr != 5'd0))
		else $error("register write event names register 0");

endmodule

bind mipsCore pipelineChecker u_pipelineChecker (
	.clk         (clk),
	.reset       (reset),
	.stall       (stall),
	.regWriteOut (regWriteOut),
	.storeOut    (storeOut)
);

`default_nettype wire

// File: tb/mipsCoreTb.sv
`timescale 1ns/100ps
`default_nettype none

module mipsCoreTb;

	logic                  clk;
	logic                  reset;
	logic                  loadValid;
	logic [7:0]            loadAddr;
	logic [31:0]           loadWord;
	mipsPkg::regWriteEvent regWriteOut;
	mipsPkg::storeEvent    storeOut;

	// Program table and the reference model state
	logic [31:0]           progWords [64];
	int                    progLength;
	int                    pos;
	logic                  skipping;
	logic [31:0]           model [32];
	logic [31:0]           modelMem [logic [31:0]];
	logic [15:0]           lfsrState;

	// Expected events in program order
	mipsPkg::regWriteEvent expRegs [$];
	mipsPkg::storeEvent    expStores [$];
	int                    regIdx;
	int                    storeIdx;
	int                    cycles;
	int                    cycleLimit;

	mipsCore u_dut (
		.clk         (clk),
		.reset       (reset),
		.loadValid   (loadValid),
		.loadAddr    (loadAddr),
		.loadWord    (loadWord),
		.regWriteOut (regWriteOut),
		.storeOut    (storeOut)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	////////////////////
	// Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsrStep(input logic [15:0] state);
		return state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
	endfunction

	function automatic logic [15:0] randomBits(input int count);
		logic [15:0] value;
		value = '0;
		for (int i = 0; i < count; i++) begin
			value = {value[14:0], lfsrState[0]};
			lfsrState = lfsrStep(lfsrState);
		end
		return value;
	endfunction

	////////////////////
	// Instruction encodings
	function automatic logic [31:0] encR(input logic [4:0] rs, input logic [4:0] rt,
		input logic [4:0] rd, input logic [5:0] funct);
		return {mipsPkg::opR, rs, rt, rd, 5'd0, funct};
	endfunction

	function automatic logic [31:0] encI(input logic [5:0] op, input logic [4:0] rs,
		input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [31:0] encJ(input logic [5:0] op, input logic [25:0] target);
		return {op, target};
	endfunction

	task automatic place(input logic [31:0] word);
		progWords[pos] = word;
		pos++;
		if (pos > progLength) begin
			progLength = pos;
		end
	endtask

	// Skipped words sit in memory but never retire
	task automatic retire(input logic [4:0] rd, input logic [31:0] value);
		mipsPkg::regWriteEvent entry;
		if (!skipping && (rd != 5'd0)) begin
			model[rd] = value;
			entry.valid = 1'b1;
			entry.addr = rd;
			entry.data = value;
			expRegs.push_back(entry);
		end
	endtask

	task automatic addu(input logic [4:0] rd, input logic [4:0] rs, input logic [4:0] rt);
		place(encR(rs, rt, rd, mipsPkg::fnAddu));
		retire(rd, model[rs] + model[rt]);
	endtask

	task automatic subu(input logic [4:0] rd, input logic [4:0] rs, input logic [4:0] rt);
		place(encR(rs, rt, rd, mipsPkg::fnSubu));
		retire(rd, model[rs] - model[rt]);
	endtask

	task automatic ori(input logic [4:0] rt, input logic [4:0] rs, input logic [15:0] imm);
		place(encI(mipsPkg::opOri, rs, rt, imm));
		retire(rt, model[rs] | {16'h0000, imm});
	endtask

	task automatic lui(input logic [4:0] rt, input logic [15:0] imm);
		place(encI(mipsPkg::opLui, 5'd0, rt, imm));
		retire(rt, {imm, 16'h0000});
	endtask

	task automatic lw(input logic [4:0] rt, input logic [4:0] rs, input logic [15:0] off);
		logic [31:0] addr;
		logic [31:0] value;
		addr = model[rs] + {{16{off[15]}}, off};
		value = modelMem.exists(addr) ? modelMem[addr] : 32'h0;
		place(encI(mipsPkg::opLw, rs, rt, off));
		retire(rt, value);
	endtask

	task automatic sw(input logic [4:0] rt, input logic [4:0] rs, input logic [15:0] off);
		mipsPkg::storeEvent entry;
		logic [31:0]        addr;
		addr = model[rs] + {{16{off[15]}}, off};
		place(encI(mipsPkg::opSw, rs, rt, off));
		if (!skipping) begin
			modelMem[addr] = model[rt];
			entry.valid = 1'b1;
			entry.addr = addr;
			entry.data = model[rt];
			expStores.push_back(entry);
		end
	endtask

	// Offset counts from the delay slot
	task automatic beq(input logic [4:0] rs, input logic [4:0] rt, input int skipCount,
		output logic taken);
		place(encI(mipsPkg::opBeq, rs, rt, 16'(skipCount + 1)));
		taken = (model[rs] == model[rt]);
	endtask

	task automatic jal(input int target);
		logic [31:0] link;
		link = 32'(pos * 4 + 8);
		place(encJ(mipsPkg::opJal, 26'(target)));
		retire(5'd31, link);
	endtask

	task automatic jr(input logic [4:0] rs);
		place(encR(rs, 5'd0, 5'd0, mipsPkg::fnJr));
	endtask

	task automatic jump(input int target);
		place(encJ(mipsPkg::opJ, 26'(target)));
	endtask

	////////////////////
	// Test program, written in execution order
	task automatic buildProgram();
		logic        taken;
		logic [15:0] offset;
		int          returnPos;
		lfsrState = 16'd76;
		pos = 0;
		progLength = 0;
		skipping = 1'b0;
		for (int i = 0; i < 64; i++) begin
			progWords[i] = 32'h0;
		end
		for (int i = 0; i < 32; i++) begin
			model[i] = 32'h0;
		end
		// ALU chain with back-to-back dependencies
		lui(5'd1, randomBits(16));
		ori(5'd1, 5'd1, randomBits(16));
		ori(5'd2, 5'd0, randomBits(16));
		addu(5'd3, 5'd1, 5'd2);
		subu(5'd4, 5'd3, 5'd1);
		addu(5'd5, 5'd4, 5'd4);
		// Stores, loads and load-use stalls
		offset = randomBits(6) << 2;
		ori(5'd6, 5'd0, offset);
		sw(5'd5, 5'd6, 16'd0);
		sw(5'd3, 5'd6, 16'd4);
		lw(5'd7, 5'd6, 16'd0);
		addu(5'd8, 5'd7, 5'd1);
		lw(5'd9, 5'd6, 16'd4);
		sw(5'd9, 5'd6, 16'd8);
		// Load then beq, two stall cycles
		lw(5'd10, 5'd6, 16'd0);
		beq(5'd10, 5'd5, 2, taken);
		addu(5'd11, 5'd10, 5'd2);
		skipping = taken;
		ori(5'd12, 5'd0, randomBits(16));
		ori(5'd13, 5'd0, randomBits(16));
		skipping = 1'b0;
		beq(5'd1, 5'd2, 1, taken);
		subu(5'd12, 5'd1, 5'd2);
		skipping = taken;
		ori(5'd13, 5'd12, randomBits(16));
		skipping = 1'b0;
		addu(5'd14, 5'd13, 5'd3);
		// Call and return, subroutine at word 40
		jal(40);
		ori(5'd15, 5'd0, randomBits(16));
		returnPos = pos;
		pos = 40;
		ori(5'd16, 5'd15, randomBits(16));
		addu(5'd17, 5'd16, 5'd14);
		jr(5'd31);
		subu(5'd18, 5'd17, 5'd31);
		pos = returnPos;
		sw(5'd17, 5'd6, 16'd12);
		addu(5'd19, 5'd18, 5'd31);
		// Park the core in a tight loop
		jump(pos);
		place(32'h0);
	endtask

	////////////////////
	// Checking
	task automatic abortRun();
		$display("Simulation FAILED");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic checkValue(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			$display("ERR at %0t: %s is %h, expected %h", $time, name, actual, expected);
			abortRun();
		end
	endtask

	function automatic logic allArrived();
		return (regIdx == expRegs.size()) && (storeIdx == expStores.size());
	endfunction

	task automatic watchEvents();
		if (regWriteOut.valid) begin
			if (regIdx >= expRegs.size()) begin
				$display("Register write to r%0d at %0t came after all expected writes",
					regWriteOut.addr, $time);
				abortRun();
			end else begin
				checkValue("regWriteOut.addr", 32'(regWriteOut.addr), 32'(expRegs[regIdx].addr));
				checkValue("regWriteOut.data", regWriteOut.data, expRegs[regIdx].data);
				regIdx++;
			end
		end
		if (storeOut.valid) begin
			if (storeIdx >= expStores.size()) begin
				$display("Store to %h at %0t came after all expected stores",
					storeOut.addr, $time);
				abortRun();
			end else begin
				checkValue("storeOut.addr", storeOut.addr, expStores[storeIdx].addr);
				checkValue("storeOut.data", storeOut.data, expStores[storeIdx].data);
				storeIdx++;
			end
		end
	endtask

	initial begin
		reset = 1'b1;
		loadValid = 1'b0;
		loadAddr = 8'd0;
		loadWord = 32'h0;
		regIdx = 0;
		storeIdx = 0;
		cycles = 0;
		buildProgram();
		cycleLimit = 8 * progLength + 50;
		repeat (2) @(posedge clk);
		// Program load stretches the reset
		for (int i = 0; i < progLength; i++) begin
			loadValid <= 1'b1;
			loadAddr <= 8'(i);
			loadWord <= progWords[i];
			@(posedge clk);
		end
		loadValid <= 1'b0;
		reset <= 1'b0;
		while (!allArrived() && (cycles < cycleLimit)) begin
			@(negedge clk);
			cycles++;
			watchEvents();
		end
		if (allArrived()) begin
			// A few quiet cycles catch surplus events
			repeat (8) begin
				@(negedge clk);
				watchEvents();
			end
			$display("Simulation PASSED");
			$finish;
		end else begin
			$display("Timeout after %0d cycles, expected events did not all arrive", cycles);
			$display("Got %0d of %0d register writes and %0d of %0d stores",
				regIdx, expRegs.size(), storeIdx, expStores.size());
			abortRun();
		end
	end

endmodule

`default_nettype wire

// File: src.f
verilog/mipsPkg.sv
verilog/controlDecoder.sv
verilog/registerFile.sv
verilog/nextPcUnit.sv
verilog/hazardUnit.sv
verilog/executeUnit.sv
verilog/memoryBank.sv
verilog/mipsCore.sv
tb/pipeline_checker.sv
tb/mipsCoreTb.sv

// File: run.sh
#!/bin/sh
# Build and run the mipsCore testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module mipsCoreTb -Mdir obj_dir -f src.f

./obj_dir/VmipsCoreTb | tee sim.log

if grep -q "Simulation PASSED" sim.log; then
	echo "run.sh: simulation passed"
else
	echo "run.sh: simulation did not pass, see sim.log"
	exit 1
fi
